/* common/chan_pkg.sv */
package chan_pkg;

    // Cache-line address width on the request channels
    localparam int addr_w = 32;

    // Request metadata, returned unchanged with every response
    localparam int mdata_w = 16;

    // One data line of a write request or read response
    localparam int line_w = 128;

    // Host MMIO offset, data and transaction id widths
    localparam int mmio_addr_w = 16;
    localparam int mmio_data_w = 64;
    localparam int mmio_tid_w = 9;

    // Writes made by the tap carry this mdata so their responses can be
    // recognised and kept away from the accelerator
    localparam logic [mdata_w-1:0] write_tag = 16'hFFFF;

    // Accelerator ID, written to DSM line 0 once the base is known
    localparam logic [line_w-1:0] afu_id = 128'h5a3c_91e4_07b2_4f6d_8c1a_e3f0_2d7b_6094;

    // Line offsets from the DSM base
    localparam logic [addr_w-1:0] dsm_id_line = 32'd0;
    localparam logic [addr_w-1:0] dsm_rsp_line = 32'd1;

    // Marker bit in a read-response line, just above the 64-bit value
    // Software polls this bit to see that the response has landed
    localparam int rsp_flag_bit = 64;

endpackage

/* common/csr_pkg.sv */
package csr_pkg;

    // DSM base register, written by host software as two 32-bit halves
    localparam logic [chan_pkg::mmio_addr_w-1:0] csr_dsm_base_lo = 16'h0110;
    localparam logic [chan_pkg::mmio_addr_w-1:0] csr_dsm_base_hi = 16'h0114;

    // Read-only window onto the low 64 bits of the accelerator ID
    localparam logic [chan_pkg::mmio_addr_w-1:0] csr_afu_id_lo = 16'h0008;

    // One decoded MMIO access per cycle
    typedef enum logic [2:0] {
        op_none,
        op_wr_base_lo,
        op_wr_base_hi,
        op_rd_base,
        op_rd_id,
        op_rd_other
    } csr_op_t;

    // Progress of the one-time ID write to DSM line 0
    typedef enum logic [1:0] {
        dsm_wait_base,
        dsm_id_pending,
        dsm_id_sent
    } dsm_state_t;

endpackage

/* logic/csr_decode.sv */
`timescale 1ns/1ps

module csr_decode (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              mmio_wr_valid,
    input  logic                              mmio_rd_valid,
    input  logic [chan_pkg::mmio_addr_w-1:0]  mmio_addr,
    input  logic [chan_pkg::mmio_data_w-1:0]  mmio_wdata,
    input  logic [chan_pkg::mmio_tid_w-1:0]   mmio_tid,
    input  logic                              rsp_taken,
    output logic [chan_pkg::addr_w-1:0]       dsm_base,
    output logic                              dsm_base_valid,
    output logic                              rsp_pending,
    output logic [chan_pkg::mmio_tid_w-1:0]   rsp_tid,
    output logic [chan_pkg::mmio_data_w-1:0]  rsp_data
);

    csr_pkg::csr_op_t op;

    // Upper half of the DSM base, kept only so software can read it back
    logic [chan_pkg::addr_w-1:0] base_hi;
    logic [chan_pkg::mmio_data_w-1:0] rd_value;
    logic rd_accept;

    // Classify the access. A write wins if the host ever strobes both
    always_comb
    begin
        op = csr_pkg::op_none;
        if (mmio_wr_valid)
        begin
            if (mmio_addr == csr_pkg::csr_dsm_base_lo)
                op = csr_pkg::op_wr_base_lo;
            else if (mmio_addr == csr_pkg::csr_dsm_base_hi)
                op = csr_pkg::op_wr_base_hi;
        end
        else if (mmio_rd_valid)
        begin
            if (mmio_addr == csr_pkg::csr_dsm_base_lo || mmio_addr == csr_pkg::csr_dsm_base_hi)
                op = csr_pkg::op_rd_base;
            else if (mmio_addr == csr_pkg::csr_afu_id_lo)
                op = csr_pkg::op_rd_id;
            else
                op = csr_pkg::op_rd_other;
        end
    end

    // Read data for this cycle's access; unknown offsets read as zero
    always_comb
    begin
        case (op)
            csr_pkg::op_rd_base: rd_value = {base_hi, dsm_base};
            csr_pkg::op_rd_id:   rd_value = chan_pkg::afu_id[chan_pkg::mmio_data_w-1:0];
            default:             rd_value = '0;
        endcase
    end

    // Only one read may be in flight, so a read that finds the holder full is lost
    assign rd_accept = (op inside {csr_pkg::op_rd_base, csr_pkg::op_rd_id, csr_pkg::op_rd_other})
                       && !rsp_pending;

    always_ff @(posedge clk)
    begin
        if (op == csr_pkg::op_wr_base_lo)
            dsm_base <= mmio_wdata[chan_pkg::addr_w-1:0];
        if (op == csr_pkg::op_wr_base_hi)
            base_hi <= mmio_wdata[chan_pkg::addr_w-1:0];
        if (rd_accept)
        begin
            rsp_tid <= mmio_tid;
            rsp_data <= rd_value;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            dsm_base_valid <= 1'b0;
            rsp_pending <= 1'b0;
        end
        else
        begin
            // Software writes the low half first, so the high write arms the base
            if (op == csr_pkg::op_wr_base_hi)
                dsm_base_valid <= 1'b1;

            if (rsp_taken)
                rsp_pending <= 1'b0;
            else if (rd_accept)
                rsp_pending <= 1'b1;
        end
    end

endmodule

/* fiu_tap/fiu_tap_inject.sv */
`timescale 1ns/1ps

module fiu_tap_inject (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              afu_c0_tx_valid,
    input  logic [chan_pkg::addr_w-1:0]       afu_c0_tx_addr,
    input  logic [chan_pkg::mdata_w-1:0]      afu_c0_tx_mdata,
    input  logic                              afu_c1_tx_valid,
    input  logic [chan_pkg::addr_w-1:0]       afu_c1_tx_addr,
    input  logic [chan_pkg::mdata_w-1:0]      afu_c1_tx_mdata,
    input  logic [chan_pkg::line_w-1:0]       afu_c1_tx_data,
    input  logic                              fiu_c1_tx_almfull,
    input  logic [chan_pkg::addr_w-1:0]       dsm_base,
    input  logic                              dsm_base_valid,
    input  logic                              rsp_pending,
    input  logic [chan_pkg::mmio_tid_w-1:0]   rsp_tid,
    input  logic [chan_pkg::mmio_data_w-1:0]  rsp_data,
    output logic                              fiu_c0_tx_valid,
    output logic [chan_pkg::addr_w-1:0]       fiu_c0_tx_addr,
    output logic [chan_pkg::mdata_w-1:0]      fiu_c0_tx_mdata,
    output logic                              fiu_c1_tx_valid,
    output logic [chan_pkg::addr_w-1:0]       fiu_c1_tx_addr,
    output logic [chan_pkg::mdata_w-1:0]      fiu_c1_tx_mdata,
    output logic [chan_pkg::line_w-1:0]       fiu_c1_tx_data,
    output logic                              afu_c1_tx_almfull,
    output logic                              rsp_taken,
    output logic                              inject_fire,
    output logic                              id_sent
);

    csr_pkg::dsm_state_t state;

    logic slot_free;
    logic id_fire;
    logic rsp_fire;
    logic [chan_pkg::line_w-1:0] rsp_line;

    // The accelerator always goes first. A slot is ours only when the
    // platform can take a write and the accelerator is not sending one
    assign slot_free = !fiu_c1_tx_almfull && !afu_c1_tx_valid;

    // The ID write can go as soon as the base is known, since the accelerator
    // waits for DSM initialisation before it does anything
    assign id_fire = slot_free && (state == csr_pkg::dsm_id_pending);

    // Read responses wait until the ID line has been written
    assign rsp_fire = slot_free && !id_fire && rsp_pending
                      && (state != csr_pkg::dsm_wait_base);

    assign inject_fire = id_fire || rsp_fire;
    assign rsp_taken = rsp_fire;
    assign id_sent = (state == csr_pkg::dsm_id_sent);

    // MMIO value in the low 64 bits and the marker bit above it
    // The tid rides just above the marker for software that wants to match it
    always_comb
    begin
        rsp_line = '0;
        rsp_line[chan_pkg::mmio_data_w-1:0] = rsp_data;
        rsp_line[chan_pkg::rsp_flag_bit] = 1'b1;
        rsp_line[chan_pkg::rsp_flag_bit+1 +: chan_pkg::mmio_tid_w] = rsp_tid;
    end

    always_comb
    begin
        // Read requests and the almost-full level pass straight through
        fiu_c0_tx_valid = afu_c0_tx_valid;
        fiu_c0_tx_addr = afu_c0_tx_addr;
        fiu_c0_tx_mdata = afu_c0_tx_mdata;
        afu_c1_tx_almfull = fiu_c1_tx_almfull;

        fiu_c1_tx_valid = afu_c1_tx_valid;
        fiu_c1_tx_addr = afu_c1_tx_addr;
        fiu_c1_tx_mdata = afu_c1_tx_mdata;
        fiu_c1_tx_data = afu_c1_tx_data;

        // Both special writes carry the driver tag
        if (id_fire)
        begin
            fiu_c1_tx_valid = 1'b1;
            fiu_c1_tx_addr = dsm_base + chan_pkg::dsm_id_line;
            fiu_c1_tx_mdata = chan_pkg::write_tag;
            fiu_c1_tx_data = chan_pkg::afu_id;
        end
        else if (rsp_fire)
        begin
            fiu_c1_tx_valid = 1'b1;
            fiu_c1_tx_addr = dsm_base + chan_pkg::dsm_rsp_line;
            fiu_c1_tx_mdata = chan_pkg::write_tag;
            fiu_c1_tx_data = rsp_line;
        end
    end

    // ID write tracking. Once sent it is never repeated until reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= csr_pkg::dsm_wait_base;
        end
        else
        begin
            case (state)
                csr_pkg::dsm_wait_base:
                    if (dsm_base_valid)
                        state <= csr_pkg::dsm_id_pending;
                csr_pkg::dsm_id_pending:
                    if (id_fire)
                        state <= csr_pkg::dsm_id_sent;
                default:
                    state <= state;
            endcase
        end
    end

endmodule

/* fiu_tap/fiu_tap_rsp_filter.sv */
`timescale 1ns/1ps

module fiu_tap_rsp_filter (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          fiu_c0_rx_rd_valid,
    input  logic                          fiu_c0_rx_wr_valid,
    input  logic [chan_pkg::mdata_w-1:0]  fiu_c0_rx_mdata,
    input  logic [chan_pkg::line_w-1:0]   fiu_c0_rx_data,
    input  logic                          fiu_c1_rx_wr_valid,
    input  logic [chan_pkg::mdata_w-1:0]  fiu_c1_rx_mdata,
    input  logic                          inject_fire,
    input  logic                          id_sent,
    output logic                          afu_c0_rx_rd_valid,
    output logic                          afu_c0_rx_wr_valid,
    output logic [chan_pkg::mdata_w-1:0]  afu_c0_rx_mdata,
    output logic [chan_pkg::line_w-1:0]   afu_c0_rx_data,
    output logic                          afu_c1_rx_wr_valid,
    output logic [chan_pkg::mdata_w-1:0]  afu_c1_rx_mdata,
    output logic                          dsm_init_done
);

    logic drop_c0;
    logic drop_c1;

    // Injected writes still waiting for their response
    logic [3:0] out_cnt;
    logic [3:0] out_cnt_next;

    // The platform may return a write response on either channel
    assign drop_c0 = fiu_c0_rx_wr_valid && (fiu_c0_rx_mdata == chan_pkg::write_tag);
    assign drop_c1 = fiu_c1_rx_wr_valid && (fiu_c1_rx_mdata == chan_pkg::write_tag);

    // Read responses are never ours, so only the write strobes are filtered
    assign afu_c0_rx_rd_valid = fiu_c0_rx_rd_valid;
    assign afu_c0_rx_wr_valid = fiu_c0_rx_wr_valid && !drop_c0;
    assign afu_c0_rx_mdata = fiu_c0_rx_mdata;
    assign afu_c0_rx_data = fiu_c0_rx_data;
    assign afu_c1_rx_wr_valid = fiu_c1_rx_wr_valid && !drop_c1;
    assign afu_c1_rx_mdata = fiu_c1_rx_mdata;

    assign out_cnt_next = out_cnt + {3'b000, inject_fire} - {3'b000, drop_c0}
                          - {3'b000, drop_c1};

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            out_cnt <= '0;
            dsm_init_done <= 1'b0;
        end
        else
        begin
            out_cnt <= out_cnt_next;
            // The ID write is the first injection, so the count draining to
            // zero after it has gone out means its response is back
            if (id_sent && (out_cnt_next == '0))
                dsm_init_done <= 1'b1;
        end
    end

endmodule

/* logic/qa_driver_top.sv */
`timescale 1ns/1ps

module qa_driver_top (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              mmio_wr_valid,
    input  logic                              mmio_rd_valid,
    input  logic [chan_pkg::mmio_addr_w-1:0]  mmio_addr,
    input  logic [chan_pkg::mmio_data_w-1:0]  mmio_wdata,
    input  logic [chan_pkg::mmio_tid_w-1:0]   mmio_tid,
    input  logic                              afu_c0_tx_valid,
    input  logic [chan_pkg::addr_w-1:0]       afu_c0_tx_addr,
    input  logic [chan_pkg::mdata_w-1:0]      afu_c0_tx_mdata,
    input  logic                              afu_c1_tx_valid,
    input  logic [chan_pkg::addr_w-1:0]       afu_c1_tx_addr,
    input  logic [chan_pkg::mdata_w-1:0]      afu_c1_tx_mdata,
    input  logic [chan_pkg::line_w-1:0]       afu_c1_tx_data,
    input  logic                              fiu_c1_tx_almfull,
    input  logic                              fiu_c0_rx_rd_valid,
    input  logic                              fiu_c0_rx_wr_valid,
    input  logic [chan_pkg::mdata_w-1:0]      fiu_c0_rx_mdata,
    input  logic [chan_pkg::line_w-1:0]       fiu_c0_rx_data,
    input  logic                              fiu_c1_rx_wr_valid,
    input  logic [chan_pkg::mdata_w-1:0]      fiu_c1_rx_mdata,
    output logic                              fiu_c0_tx_valid,
    output logic [chan_pkg::addr_w-1:0]       fiu_c0_tx_addr,
    output logic [chan_pkg::mdata_w-1:0]      fiu_c0_tx_mdata,
    output logic                              fiu_c1_tx_valid,
    output logic [chan_pkg::addr_w-1:0]       fiu_c1_tx_addr,
    output logic [chan_pkg::mdata_w-1:0]      fiu_c1_tx_mdata,
    output logic [chan_pkg::line_w-1:0]       fiu_c1_tx_data,
    output logic                              afu_c1_tx_almfull,
    output logic                              afu_c0_rx_rd_valid,
    output logic                              afu_c0_rx_wr_valid,
    output logic [chan_pkg::mdata_w-1:0]      afu_c0_rx_mdata,
    output logic [chan_pkg::line_w-1:0]       afu_c0_rx_data,
    output logic                              afu_c1_rx_wr_valid,
    output logic [chan_pkg::mdata_w-1:0]      afu_c1_rx_mdata,
    output logic                              dsm_init_done
);

    // Decoder to injector
    logic [chan_pkg::addr_w-1:0] dsm_base;
    logic dsm_base_valid;
    logic rsp_pending;
    logic [chan_pkg::mmio_tid_w-1:0] rsp_tid;
    logic [chan_pkg::mmio_data_w-1:0] rsp_data;
    logic rsp_taken;

    // Injector to filter
    logic inject_fire;
    logic id_sent;

    // CSR decoder, write injector and response filter of the tap
    csr_decode u_csr_decode (.*);

    fiu_tap_inject u_fiu_tap_inject (.*);

    fiu_tap_rsp_filter u_fiu_tap_rsp_filter (.*);

endmodule

/* test/tb_qa_driver.sv */
`timescale 1ns/1ps

module tb_qa_driver;

    localparam logic [31:0] base_lo = 32'h0004_2000;
    localparam logic [31:0] base_hi = 32'h0000_0003;

    logic clk;
    logic reset_n;
    logic mmio_wr_valid;
    logic mmio_rd_valid;
    logic [chan_pkg::mmio_addr_w-1:0] mmio_addr;
    logic [chan_pkg::mmio_data_w-1:0] mmio_wdata;
    logic [chan_pkg::mmio_tid_w-1:0] mmio_tid;
    logic afu_c0_tx_valid;
    logic [chan_pkg::addr_w-1:0] afu_c0_tx_addr;
    logic [chan_pkg::mdata_w-1:0] afu_c0_tx_mdata;
    logic afu_c1_tx_valid;
    logic [chan_pkg::addr_w-1:0] afu_c1_tx_addr;
    logic [chan_pkg::mdata_w-1:0] afu_c1_tx_mdata;
    logic [chan_pkg::line_w-1:0] afu_c1_tx_data;
    logic fiu_c1_tx_almfull;
    logic fiu_c0_rx_rd_valid;
    logic fiu_c0_rx_wr_valid;
    logic [chan_pkg::mdata_w-1:0] fiu_c0_rx_mdata;
    logic [chan_pkg::line_w-1:0] fiu_c0_rx_data;
    logic fiu_c1_rx_wr_valid;
    logic [chan_pkg::mdata_w-1:0] fiu_c1_rx_mdata;
    logic fiu_c0_tx_valid;
    logic [chan_pkg::addr_w-1:0] fiu_c0_tx_addr;
    logic [chan_pkg::mdata_w-1:0] fiu_c0_tx_mdata;
    logic fiu_c1_tx_valid;
    logic [chan_pkg::addr_w-1:0] fiu_c1_tx_addr;
    logic [chan_pkg::mdata_w-1:0] fiu_c1_tx_mdata;
    logic [chan_pkg::line_w-1:0] fiu_c1_tx_data;
    logic afu_c1_tx_almfull;
    logic afu_c0_rx_rd_valid;
    logic afu_c0_rx_wr_valid;
    logic [chan_pkg::mdata_w-1:0] afu_c0_rx_mdata;
    logic [chan_pkg::line_w-1:0] afu_c0_rx_data;
    logic afu_c1_rx_wr_valid;
    logic [chan_pkg::mdata_w-1:0] afu_c1_rx_mdata;
    logic dsm_init_done;

    int errors;
    int timeouts;
    integer seed;

    // Every write that reaches the platform is logged here in order
    logic [chan_pkg::addr_w-1:0] wr_addr_q[$];
    logic [chan_pkg::mdata_w-1:0] wr_mdata_q[$];
    logic [chan_pkg::line_w-1:0] wr_data_q[$];

    qa_driver_top DUT (.*);

    always #2 clk = ~clk;

    // The platform accepts one write per cycle and keeps its fields
    always @(posedge clk)
    begin
        if (reset_n && fiu_c1_tx_valid)
        begin
            wr_addr_q.push_back(fiu_c1_tx_addr);
            wr_mdata_q.push_back(fiu_c1_tx_mdata);
            wr_data_q.push_back(fiu_c1_tx_data);
        end
    end

    // Guard against a stuck run
    initial
    begin
        #100000;
        $display("Simulation ran past its time limit and was stopped");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_equal(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (act !== exp)
        begin
            errors++;
            $display("FAIL at %0t ns %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // Returns once the platform has logged more than n writes
    task automatic wait_for_write(input int n);
        int cycles;
        cycles = 0;
        while (wr_addr_q.size() <= n && cycles < 50)
        begin
            @(negedge clk);
            cycles++;
        end
        if (wr_addr_q.size() <= n)
        begin
            timeouts++;
            $display("No platform write appeared within 50 cycles at %0t ns", $time);
        end
    endtask

    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        @(posedge clk);
        mmio_wr_valid <= 1'b1;
        mmio_addr <= addr;
        mmio_wdata <= data;
        @(posedge clk);
        mmio_wr_valid <= 1'b0;
    endtask

    task automatic mmio_read(input logic [15:0] addr, input logic [8:0] tid);
        @(posedge clk);
        mmio_rd_valid <= 1'b1;
        mmio_addr <= addr;
        mmio_tid <= tid;
        @(posedge clk);
        mmio_rd_valid <= 1'b0;
    endtask

    // A response line lands one above the base with the marker bit set
    task automatic check_rsp_line(input int n, input logic [63:0] value);
        logic [127:0] line;
        line = wr_data_q[n];
        check_equal("fiu_c1_tx_addr", 128'(base_lo + 32'd1), 128'(wr_addr_q[n]));
        check_equal("fiu_c1_tx_mdata", 128'(16'hFFFF), 128'(wr_mdata_q[n]));
        check_equal("fiu_c1_tx_data[63:0]", 128'(value), 128'(line[63:0]));
        check_equal("fiu_c1_tx_data[64]", 128'(1'b1), 128'(line[64]));
    endtask

    task automatic test_id_write();
        repeat (20) @(negedge clk);
        check_equal("write count before base", 128'(0), 128'(wr_addr_q.size()));
        mmio_write(csr_pkg::csr_dsm_base_lo, {32'h0, base_lo});
        mmio_write(csr_pkg::csr_dsm_base_hi, {32'h0, base_hi});
        wait_for_write(0);
        repeat (10) @(negedge clk);
        check_equal("write count after base", 128'(1), 128'(wr_addr_q.size()));
        check_equal("fiu_c1_tx_addr", 128'(base_lo), 128'(wr_addr_q[0]));
        check_equal("fiu_c1_tx_mdata", 128'(16'hFFFF), 128'(wr_mdata_q[0]));
        check_equal("fiu_c1_tx_data", chan_pkg::afu_id, wr_data_q[0]);
    endtask

    task automatic test_rsp_filter();
        int cycles;
        cycles = 0;
        check_equal("dsm_init_done", 128'(1'b0), 128'(dsm_init_done));
        // Response to the ID write comes back on c1 and must be hidden
        @(posedge clk);
        fiu_c1_rx_wr_valid <= 1'b1;
        fiu_c1_rx_mdata <= 16'hFFFF;
        @(negedge clk);
        check_equal("afu_c1_rx_wr_valid", 128'(1'b0), 128'(afu_c1_rx_wr_valid));
        @(posedge clk);
        fiu_c1_rx_wr_valid <= 1'b0;
        while (!dsm_init_done && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!dsm_init_done)
        begin
            timeouts++;
            $display("dsm_init_done did not rise after the ID write response");
        end
        @(posedge clk);
        fiu_c0_rx_wr_valid <= 1'b1;
        fiu_c0_rx_mdata <= 16'hFFFF;
        @(negedge clk);
        check_equal("afu_c0_rx_wr_valid", 128'(1'b0), 128'(afu_c0_rx_wr_valid));
        // Untagged responses belong to the accelerator
        @(posedge clk);
        fiu_c0_rx_mdata <= 16'h0042;
        fiu_c1_rx_wr_valid <= 1'b1;
        fiu_c1_rx_mdata <= 16'h1234;
        @(negedge clk);
        check_equal("afu_c0_rx_wr_valid", 128'(1'b1), 128'(afu_c0_rx_wr_valid));
        check_equal("afu_c1_rx_wr_valid", 128'(1'b1), 128'(afu_c1_rx_wr_valid));
        check_equal("afu_c1_rx_mdata", 128'(16'h1234), 128'(afu_c1_rx_mdata));
        @(posedge clk);
        fiu_c0_rx_wr_valid <= 1'b0;
        fiu_c1_rx_wr_valid <= 1'b0;
    endtask

    task automatic test_backpressure();
        logic [31:0] r0;
        logic [31:0] r1;
        int n;
        @(posedge clk);
        afu_c1_tx_valid <= 1'b1;
        afu_c1_tx_addr <= 32'h0010_0000;
        afu_c1_tx_mdata <= 16'h0100;
        afu_c1_tx_data <= 128'h1;
        mmio_read(csr_pkg::csr_dsm_base_lo, 9'h003);
        // The accelerator owns every slot, so its writes pass untouched
        repeat (8)
        begin
            r0 = $random(seed);
            r1 = $random(seed);
            @(posedge clk);
            afu_c1_tx_addr <= r0;
            afu_c1_tx_mdata <= r1[15:0];
            afu_c1_tx_data <= {r0, r1, r1, r0};
            @(negedge clk);
            check_equal("fiu_c1_tx_valid", 128'(1'b1), 128'(fiu_c1_tx_valid));
            check_equal("fiu_c1_tx_addr", 128'(afu_c1_tx_addr), 128'(fiu_c1_tx_addr));
            check_equal("fiu_c1_tx_mdata", 128'(afu_c1_tx_mdata), 128'(fiu_c1_tx_mdata));
            check_equal("fiu_c1_tx_data", afu_c1_tx_data, fiu_c1_tx_data);
        end
        @(posedge clk);
        afu_c1_tx_valid <= 1'b0;
        fiu_c1_tx_almfull <= 1'b1;
        repeat (6)
        begin
            @(negedge clk);
            check_equal("fiu_c1_tx_valid", 128'(1'b0), 128'(fiu_c1_tx_valid));
            check_equal("afu_c1_tx_almfull", 128'(1'b1), 128'(afu_c1_tx_almfull));
        end
        n = wr_addr_q.size();
        @(posedge clk);
        fiu_c1_tx_almfull <= 1'b0;
        wait_for_write(n);
        check_rsp_line(n, {base_hi, base_lo});
    endtask

    task automatic test_rsp_write();
        int n;
        n = wr_addr_q.size();
        mmio_read(csr_pkg::csr_dsm_base_lo, 9'h005);
        wait_for_write(n);
        check_rsp_line(n, {base_hi, base_lo});
        // Offsets the decoder does not know read back as zero
        n = wr_addr_q.size();
        mmio_read(16'h0200, 9'h006);
        wait_for_write(n);
        check_rsp_line(n, 64'h0);
    endtask

    task automatic test_read_passthru();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        repeat (20)
        begin
            r0 = $random(seed);
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            @(posedge clk);
            afu_c0_tx_valid <= r0[0];
            afu_c0_tx_addr <= r1;
            afu_c0_tx_mdata <= r0[31:16];
            fiu_c0_rx_rd_valid <= r0[1];
            fiu_c0_rx_mdata <= r2[15:0];
            fiu_c0_rx_data <= {r3, r2, r1, r0};
            @(negedge clk);
            check_equal("fiu_c0_tx_valid/addr/mdata",
                        128'({afu_c0_tx_valid, afu_c0_tx_addr, afu_c0_tx_mdata}),
                        128'({fiu_c0_tx_valid, fiu_c0_tx_addr, fiu_c0_tx_mdata}));
            check_equal("afu_c0_rx_rd_valid/mdata",
                        128'({fiu_c0_rx_rd_valid, fiu_c0_rx_mdata}),
                        128'({afu_c0_rx_rd_valid, afu_c0_rx_mdata}));
            check_equal("afu_c0_rx_data", fiu_c0_rx_data, afu_c0_rx_data);
        end
    endtask

    initial
    begin
        errors = 0;
        timeouts = 0;
        seed = 37198;
        clk = 1'b0;
        reset_n = 1'b0;
        mmio_wr_valid = 1'b0;
        mmio_rd_valid = 1'b0;
        mmio_addr = '0;
        mmio_wdata = '0;
        mmio_tid = '0;
        afu_c0_tx_valid = 1'b0;
        afu_c0_tx_addr = '0;
        afu_c0_tx_mdata = '0;
        afu_c1_tx_valid = 1'b0;
        afu_c1_tx_addr = '0;
        afu_c1_tx_mdata = '0;
        afu_c1_tx_data = '0;
        fiu_c1_tx_almfull = 1'b0;
        fiu_c0_rx_rd_valid = 1'b0;
        fiu_c0_rx_wr_valid = 1'b0;
        fiu_c0_rx_mdata = '0;
        fiu_c0_rx_data = '0;
        fiu_c1_rx_wr_valid = 1'b0;
        fiu_c1_rx_mdata = '0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        // The filter test runs right after the ID write so that write is the only one in flight
        test_id_write();
        test_rsp_filter();
        test_backpressure();
        test_rsp_write();
        test_read_passthru();

        repeat (5) @(posedge clk);
        $display("Value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* list.f */
common/chan_pkg.sv
common/csr_pkg.sv
logic/csr_decode.sv
fiu_tap/fiu_tap_inject.sv
fiu_tap/fiu_tap_rsp_filter.sv
logic/qa_driver_top.sv
test/tb_qa_driver.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_qa_driver
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
